// ==== src/demosaic_pkg.sv ====
// demosaic widths, limits, register map, beat structs and scan states
package demosaic_pkg;

	// sample and position widths
	localparam int PIX_W    = 10;
	localparam int LINE_MAX = 64;
	localparam int COL_W    = 7;
	localparam int LBUF_AW  = $clog2(LINE_MAX);

	// wishbone port widths
	localparam int WB_ADR_W = 4;
	localparam int WB_DAT_W = 32;

	typedef logic [PIX_W-1:0]    pix_t;
	typedef logic [COL_W-1:0]    col_t;
	typedef logic [1:0]          phase_t;
	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;

	// register map, word addresses
	localparam wb_adr_t REG_ADR_PHASE  = 4'd0;
	localparam wb_adr_t REG_ADR_BYPASS = 4'd1;

	localparam phase_t PHASE_RST  = 2'b11;
	localparam logic   BYPASS_RST = 1'b0;

	typedef struct packed {
		pix_t raw;
		logic line_first;
		logic line_last;
		logic pixel_first;
		logic pixel_last;
	} raw_beat_t;

	// 3x3 neighbourhood, rows top to bottom, columns left to right
	typedef struct packed {
		pix_t above_left;
		pix_t above_mid;
		pix_t above_right;
		pix_t center_left;
		pix_t center_mid;
		pix_t center_right;
		pix_t below_left;
		pix_t below_mid;
		pix_t below_right;
	} window_t;

	typedef struct packed {
		pix_t r;
		pix_t g;
		pix_t b;
		pix_t raw;
		logic line_first;
		logic line_last;
		logic pixel_first;
		logic pixel_last;
	} rgb_beat_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FLUSH
	} scan_state_t;

endpackage

// ==== src/demosaic_regs.sv ====
// wishbone register slave holding the bayer phase and the bypass bit
`timescale 1ns/1ps

module demosaic_regs
	import demosaic_pkg::*;
(
	input  logic    clk,
	input  logic    s_wb_rst_i,
	input  wb_adr_t s_wb_adr_i,
	input  wb_dat_t s_wb_dat_i,
	output wb_dat_t s_wb_dat_o,
	input  logic    s_wb_we_i,
	input  logic    s_wb_stb_i,
	output logic    s_wb_ack_o,
	output phase_t  phase_o,
	output logic    bypass_o
);

	phase_t phase_q;
	logic   bypass_q;

	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			phase_q  <= PHASE_RST;
			bypass_q <= BYPASS_RST;
		end else if (s_wb_stb_i && s_wb_we_i) begin
			case (s_wb_adr_i)
				REG_ADR_PHASE:  phase_q  <= s_wb_dat_i[1:0];
				REG_ADR_BYPASS: bypass_q <= s_wb_dat_i[0];
				default: ;
			endcase
		end
	end

	// readback straight from the address with unmapped words reading zero
	always_comb begin
		case (s_wb_adr_i)
			REG_ADR_PHASE:  s_wb_dat_o = wb_dat_t'(phase_q);
			REG_ADR_BYPASS: s_wb_dat_o = wb_dat_t'(bypass_q);
			default:        s_wb_dat_o = '0;
		endcase
	end

	// single cycle bus where every strobe is acknowledged at once
	assign s_wb_ack_o = s_wb_stb_i;

	assign phase_o  = phase_q;
	assign bypass_o = bypass_q;

	a_ack_needs_stb: assert property (@(posedge clk) s_wb_ack_o |-> s_wb_stb_i);

endmodule

// ==== src/demosaic_scan_ctrl.sv ====
// frame state machine: input accept, end-of-frame flush, per-frame settings
`timescale 1ns/1ps

module demosaic_scan_ctrl
	import demosaic_pkg::*;
(
	input  logic      clk,
	input  logic      s_wb_rst_i,
	input  logic      s_img_valid_i,
	input  raw_beat_t s_img_beat_i,
	output logic      s_img_ready_o,
	input  phase_t    phase_i,
	input  logic      bypass_i,
	input  col_t      width_i,
	input  logic      flush_done_i,
	output logic      slot_o,
	output logic      flush_o,
	output logic      frame_start_o,
	output logic      frame_end_o,
	output phase_t    phase_o,
	output logic      bypass_o
);

	scan_state_t state_q;
	scan_state_t state_d;
	phase_t      phase_q;
	logic        bypass_q;
	logic        accept;
	logic        is_start;
	logic        is_end;

	// the source is only held off while the last line drains
	assign s_img_ready_o = (state_q != FLUSH);
	assign flush_o       = (state_q == FLUSH);

	assign accept   = s_img_valid_i && s_img_ready_o;
	assign is_start = s_img_beat_i.line_first && s_img_beat_i.pixel_first;
	assign is_end   = s_img_beat_i.line_last && s_img_beat_i.pixel_last;

	always_comb begin
		state_d       = state_q;
		slot_o        = 1'b0;
		frame_start_o = 1'b0;
		frame_end_o   = 1'b0;
		case (state_q)
			IDLE: begin
				// beats before a frame start are taken and thrown away
				if (accept && is_start) begin
					slot_o        = 1'b1;
					frame_start_o = 1'b1;
					frame_end_o   = is_end;
					state_d       = is_end ? FLUSH : RUN;
				end
			end
			RUN: begin
				slot_o = accept;
				if (accept && is_end) begin
					frame_end_o = 1'b1;
					state_d     = FLUSH;
				end
			end
			FLUSH: begin
				// one zero sample per cycle until the last line is out
				slot_o = 1'b1;
				if (flush_done_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			state_q  <= IDLE;
			phase_q  <= PHASE_RST;
			bypass_q <= BYPASS_RST;
		end else begin
			state_q <= state_d;
			// settings hold for the whole frame
			if (frame_start_o) begin
				phase_q  <= phase_i;
				bypass_q <= bypass_i;
			end
		end
	end

	assign phase_o  = phase_q;
	assign bypass_o = bypass_q;

	// source stays stalled from the last beat until the counters end the flush
	a_ready_low_in_flush: assert property (@(posedge clk) disable iff (s_wb_rst_i)
		frame_end_o |=> !s_img_ready_o until_with flush_done_i);

	// flush length relies on a width learned from the first line
	a_width_known: assert property (@(posedge clk) disable iff (s_wb_rst_i)
		flush_o |-> width_i != '0);

endmodule

// ==== src/demosaic_pos_cnt.sv ====
// input and output position counters, learned frame size, edge flags, markers
`timescale 1ns/1ps

module demosaic_pos_cnt
	import demosaic_pkg::*;
(
	input  logic      clk,
	input  logic      s_wb_rst_i,
	input  logic      slot_i,
	input  logic      flush_i,
	input  logic      frame_start_i,
	input  raw_beat_t beat_i,
	output col_t      width_o,
	output col_t      in_col_o,
	output logic      flush_done_o,
	output logic      out_valid_o,
	output col_t      out_x_o,
	output col_t      out_y_o,
	output logic      edge_top_o,
	output logic      edge_left_o,
	output logic      edge_right_o,
	output logic      out_line_first_o,
	output logic      out_line_last_o,
	output logic      out_pixel_first_o,
	output logic      out_pixel_last_o
);

	col_t in_x_q;
	col_t in_y_q;
	col_t cur_x;
	col_t cur_y;
	col_t width_q;
	col_t height_q;
	col_t out_x_q;
	col_t out_y_q;
	col_t flush_cnt_q;
	col_t last_x;
	logic in_slot;
	logic last_col;
	logic out_active;

	// the frame start beat is always raster position zero
	assign cur_x   = frame_start_i ? '0 : in_x_q;
	assign cur_y   = frame_start_i ? '0 : in_y_q;
	assign last_x  = col_t'(width_q - 1'b1);
	assign in_slot = slot_i && !flush_i;

	// flush slots have no markers, so they wrap on the learned width
	assign last_col = flush_i ? (cur_x == last_x) : beat_i.pixel_last;

	// centre pixel exists once a full line plus one sample has gone in
	assign out_active = slot_i && (cur_y > col_t'(1) || (cur_y == col_t'(1) && cur_x != '0));

	assign flush_done_o = slot_i && flush_i && (flush_cnt_q == width_q);

	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			in_x_q      <= '0;
			in_y_q      <= '0;
			width_q     <= '0;
			height_q    <= '0;
			out_x_q     <= '0;
			out_y_q     <= '0;
			flush_cnt_q <= '0;
		end else begin
			if (slot_i) begin
				if (last_col) begin
					in_x_q <= '0;
					in_y_q <= col_t'(cur_y + 1'b1);
				end else begin
					in_x_q <= col_t'(cur_x + 1'b1);
					in_y_q <= cur_y;
				end
			end
			if (in_slot && cur_y == '0 && beat_i.pixel_last) begin
				width_q <= col_t'(cur_x + 1'b1);
			end
			// height stays zero until the frame end beat, so no early last line
			if (frame_start_i) begin
				height_q <= '0;
			end
			if (in_slot && beat_i.line_last && beat_i.pixel_last) begin
				height_q <= col_t'(cur_y + 1'b1);
			end
			if (frame_start_i) begin
				out_x_q <= '0;
				out_y_q <= '0;
			end else if (out_active) begin
				if (out_x_q == last_x) begin
					out_x_q <= '0;
					out_y_q <= col_t'(out_y_q + 1'b1);
				end else begin
					out_x_q <= col_t'(out_x_q + 1'b1);
				end
			end
			if (flush_done_o) begin
				flush_cnt_q <= '0;
			end else if (slot_i && flush_i) begin
				flush_cnt_q <= col_t'(flush_cnt_q + 1'b1);
			end
		end
	end

	assign width_o     = width_q;
	assign in_col_o    = cur_x;
	assign out_valid_o = out_active;
	assign out_x_o     = out_x_q;
	assign out_y_o     = out_y_q;

	assign edge_top_o   = (out_y_q == '0);
	assign edge_left_o  = (out_x_q == '0);
	assign edge_right_o = (out_x_q == last_x);

	assign out_line_first_o  = (out_y_q == '0);
	assign out_line_last_o   = (col_t'(out_y_q + 1'b1) == height_q);
	assign out_pixel_first_o = (out_x_q == '0);
	assign out_pixel_last_o  = (out_x_q == last_x);

	a_width_limit: assert property (@(posedge clk) disable iff (s_wb_rst_i)
		width_q <= LINE_MAX);

endmodule

// ==== src/demosaic_line_buf.sv ====
// two line memories and the 3x3 window shifter
`timescale 1ns/1ps

module demosaic_line_buf
	import demosaic_pkg::*;
(
	input  logic    clk,
	input  logic    slot_i,
	input  logic    flush_i,
	input  pix_t    raw_i,
	input  col_t    wr_col_i,
	output window_t window_o
);

	pix_t                mem1 [LINE_MAX];
	pix_t                mem2 [LINE_MAX];
	logic [LBUF_AW-1:0]  adr;
	pix_t                new_pix;
	pix_t                rd1;
	pix_t                rd2;
	pix_t                above_mid_q;
	pix_t                above_left_q;
	pix_t                center_mid_q;
	pix_t                center_left_q;
	pix_t                below_mid_q;
	pix_t                below_left_q;

	assign adr     = wr_col_i[LBUF_AW-1:0];
	assign new_pix = flush_i ? '0 : raw_i;

	// old contents: rd1 is one line back, rd2 two lines back
	assign rd1 = mem1[adr];
	assign rd2 = mem2[adr];

	always_ff @(posedge clk) begin
		if (slot_i) begin
			mem1[adr] <= new_pix;
			mem2[adr] <= rd1;

			above_left_q  <= above_mid_q;
			above_mid_q   <= rd2;
			center_left_q <= center_mid_q;
			center_mid_q  <= rd1;
			below_left_q  <= below_mid_q;
			below_mid_q   <= new_pix;
		end
	end

	// right column is live, so the window is complete within the slot
	assign window_o.above_right  = rd2;
	assign window_o.above_mid    = above_mid_q;
	assign window_o.above_left   = above_left_q;
	assign window_o.center_right = rd1;
	assign window_o.center_mid   = center_mid_q;
	assign window_o.center_left  = center_left_q;
	assign window_o.below_right  = new_pix;
	assign window_o.below_mid    = below_mid_q;
	assign window_o.below_left   = below_left_q;

endmodule

// ==== src/demosaic_interp.sv ====
// edge masking, bayer colour selection, bilinear averages and output register
`timescale 1ns/1ps

module demosaic_interp
	import demosaic_pkg::*;
(
	input  logic      clk,
	input  logic      s_wb_rst_i,
	input  logic      valid_i,
	input  window_t   window_i,
	input  col_t      x_i,
	input  col_t      y_i,
	input  logic      edge_top_i,
	input  logic      edge_left_i,
	input  logic      edge_right_i,
	input  logic      line_first_i,
	input  logic      line_last_i,
	input  logic      pixel_first_i,
	input  logic      pixel_last_i,
	input  phase_t    phase_i,
	input  logic      bypass_i,
	output logic      m_img_valid_o,
	output rgb_beat_t m_img_beat_o
);

	pix_t             a_l;
	pix_t             a_m;
	pix_t             a_r;
	pix_t             c_l;
	pix_t             c_m;
	pix_t             c_r;
	pix_t             b_l;
	pix_t             b_m;
	pix_t             b_r;
	logic [PIX_W+1:0] sum_orth;
	logic [PIX_W+1:0] sum_diag;
	logic [PIX_W:0]   sum_horz;
	logic [PIX_W:0]   sum_vert;
	pix_t             avg_orth;
	pix_t             avg_diag;
	pix_t             avg_horz;
	pix_t             avg_vert;
	logic             cx;
	logic             cy;
	rgb_beat_t        beat_d;

	// samples outside the image count as zero
	// below row needs no mask, flush already feeds zeros
	assign a_l = (edge_top_i || edge_left_i) ? '0 : window_i.above_left;
	assign a_m = edge_top_i ? '0 : window_i.above_mid;
	assign a_r = (edge_top_i || edge_right_i) ? '0 : window_i.above_right;
	assign c_l = edge_left_i ? '0 : window_i.center_left;
	assign c_m = window_i.center_mid;
	assign c_r = edge_right_i ? '0 : window_i.center_right;
	assign b_l = edge_left_i ? '0 : window_i.below_left;
	assign b_m = window_i.below_mid;
	assign b_r = edge_right_i ? '0 : window_i.below_right;

	assign sum_orth = {2'b00, a_m} + {2'b00, c_l} + {2'b00, c_r} + {2'b00, b_m};
	assign sum_diag = {2'b00, a_l} + {2'b00, a_r} + {2'b00, b_l} + {2'b00, b_r};
	assign sum_horz = {1'b0, c_l} + {1'b0, c_r};
	assign sum_vert = {1'b0, a_m} + {1'b0, b_m};

	// truncating divides
	assign avg_orth = sum_orth[PIX_W+1:2];
	assign avg_diag = sum_diag[PIX_W+1:2];
	assign avg_horz = sum_horz[PIX_W:1];
	assign avg_vert = sum_vert[PIX_W:1];

	// phase flips column and row parity
	assign cx = x_i[0] ^ phase_i[0];
	assign cy = y_i[0] ^ phase_i[1];

	always_comb begin
		beat_d.raw         = c_m;
		beat_d.line_first  = line_first_i;
		beat_d.line_last   = line_last_i;
		beat_d.pixel_first = pixel_first_i;
		beat_d.pixel_last  = pixel_last_i;
		if (bypass_i) begin
			beat_d.r = c_m;
			beat_d.g = c_m;
			beat_d.b = c_m;
		end else begin
			case ({cy, cx})
				2'b00: begin
					beat_d.r = c_m;
					beat_d.g = avg_orth;
					beat_d.b = avg_diag;
				end
				2'b11: begin
					beat_d.r = avg_diag;
					beat_d.g = avg_orth;
					beat_d.b = c_m;
				end
				// green on a red row
				2'b01: begin
					beat_d.r = avg_horz;
					beat_d.g = c_m;
					beat_d.b = avg_vert;
				end
				default: begin
					beat_d.r = avg_vert;
					beat_d.g = c_m;
					beat_d.b = avg_horz;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			m_img_valid_o <= 1'b0;
		end else begin
			m_img_valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			m_img_beat_o <= beat_d;
		end
	end

endmodule

// ==== src/demosaic_top.sv ====
// demosaic top: registers, frame control, counters, line buffer, interpolator
`timescale 1ns/1ps

module demosaic_top
	import demosaic_pkg::*;
(
	input  logic      clk,
	input  logic      s_wb_rst_i,
	input  wb_adr_t   s_wb_adr_i,
	input  wb_dat_t   s_wb_dat_i,
	output wb_dat_t   s_wb_dat_o,
	input  logic      s_wb_we_i,
	input  logic      s_wb_stb_i,
	output logic      s_wb_ack_o,
	input  logic      s_img_valid_i,
	input  raw_beat_t s_img_beat_i,
	output logic      s_img_ready_o,
	output logic      m_img_valid_o,
	output rgb_beat_t m_img_beat_o
);

	phase_t  reg_phase;
	logic    reg_bypass;
	phase_t  frame_phase;
	logic    frame_bypass;
	logic    slot;
	logic    flush;
	logic    frame_start;
	logic    flush_done;
	col_t    width;
	col_t    in_col;
	logic    out_valid;
	col_t    out_x;
	col_t    out_y;
	logic    edge_top;
	logic    edge_left;
	logic    edge_right;
	logic    out_line_first;
	logic    out_line_last;
	logic    out_pixel_first;
	logic    out_pixel_last;
	window_t window;

	demosaic_regs regs_i (
		.clk        (clk),
		.s_wb_rst_i (s_wb_rst_i),
		.s_wb_adr_i (s_wb_adr_i),
		.s_wb_dat_i (s_wb_dat_i),
		.s_wb_dat_o (s_wb_dat_o),
		.s_wb_we_i  (s_wb_we_i),
		.s_wb_stb_i (s_wb_stb_i),
		.s_wb_ack_o (s_wb_ack_o),
		.phase_o    (reg_phase),
		.bypass_o   (reg_bypass)
	);

	demosaic_scan_ctrl ctrl_i (
		.clk           (clk),
		.s_wb_rst_i    (s_wb_rst_i),
		.s_img_valid_i (s_img_valid_i),
		.s_img_beat_i  (s_img_beat_i),
		.s_img_ready_o (s_img_ready_o),
		.phase_i       (reg_phase),
		.bypass_i      (reg_bypass),
		.width_i       (width),
		.flush_done_i  (flush_done),
		.slot_o        (slot),
		.flush_o       (flush),
		.frame_start_o (frame_start),
		.frame_end_o   (),
		.phase_o       (frame_phase),
		.bypass_o      (frame_bypass)
	);

	demosaic_pos_cnt cnt_i (
		.clk               (clk),
		.s_wb_rst_i        (s_wb_rst_i),
		.slot_i            (slot),
		.flush_i           (flush),
		.frame_start_i     (frame_start),
		.beat_i            (s_img_beat_i),
		.width_o           (width),
		.in_col_o          (in_col),
		.flush_done_o      (flush_done),
		.out_valid_o       (out_valid),
		.out_x_o           (out_x),
		.out_y_o           (out_y),
		.edge_top_o        (edge_top),
		.edge_left_o       (edge_left),
		.edge_right_o      (edge_right),
		.out_line_first_o  (out_line_first),
		.out_line_last_o   (out_line_last),
		.out_pixel_first_o (out_pixel_first),
		.out_pixel_last_o  (out_pixel_last)
	);

	demosaic_line_buf lbuf_i (
		.clk      (clk),
		.slot_i   (slot),
		.flush_i  (flush),
		.raw_i    (s_img_beat_i.raw),
		.wr_col_i (in_col),
		.window_o (window)
	);

	demosaic_interp interp_i (
		.clk           (clk),
		.s_wb_rst_i    (s_wb_rst_i),
		.valid_i       (out_valid),
		.window_i      (window),
		.x_i           (out_x),
		.y_i           (out_y),
		.edge_top_i    (edge_top),
		.edge_left_i   (edge_left),
		.edge_right_i  (edge_right),
		.line_first_i  (out_line_first),
		.line_last_i   (out_line_last),
		.pixel_first_i (out_pixel_first),
		.pixel_last_i  (out_pixel_last),
		.phase_i       (frame_phase),
		.bypass_i      (frame_bypass),
		.m_img_valid_o (m_img_valid_o),
		.m_img_beat_o  (m_img_beat_o)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock (8 ns period) and reset held for four cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// release lines up with the stimulus drive point after the edge
	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

// ==== dv/tb_demosaic_chk.sv ====
// monitor with register model, reference demosaic model and output comparison
`timescale 1ns/1ps

module tb_demosaic_chk
	import demosaic_pkg::*;
(
	input  logic      clk,
	input  logic      s_wb_rst_i,
	input  wb_adr_t   wb_adr_i,
	input  wb_dat_t   wb_wdat_i,
	input  wb_dat_t   wb_rdat_i,
	input  logic      wb_we_i,
	input  logic      wb_stb_i,
	input  logic      wb_ack_i,
	input  logic      img_valid_i,
	input  raw_beat_t img_beat_i,
	input  logic      img_ready_i,
	input  logic      out_valid_i,
	input  rgb_beat_t out_beat_i,
	output int        err_cnt_o,
	output int        frames_o
);

	phase_t reg_phase;
	logic   reg_bypass;
	phase_t frm_phase;
	logic   frm_bypass;
	pix_t   pix_q[$];
	int     width;
	int     height;
	int     out_cnt;
	int     flush_cycles;
	logic   in_frame;
	logic   ended;
	logic   flushing;

	initial begin
		err_cnt_o = 0;
		frames_o  = 0;
	end

	task automatic compare(input string name, input int exp, input int got, input string where);
		if (exp != got) begin
			$display("ERR %s exp 0x%0h got 0x%0h (%s)", name, exp, got, where);
			err_cnt_o++;
		end
	endtask

	task automatic fail_msg(input string text);
		$display("%s", text);
		err_cnt_o++;
	endtask

	// samples outside the image, the row below the last one included, are zero
	function automatic int pix_at(input int x, input int y);
		int idx;
		if (x < 0 || x >= width || y < 0) begin
			return 0;
		end
		idx = y * width + x;
		if (idx >= pix_q.size()) begin
			return 0;
		end
		return pix_q[idx];
	endfunction

	task automatic check_bus();
		int exp;
		if (wb_ack_i !== wb_stb_i) begin
			compare("s_wb_ack_o", wb_stb_i, wb_ack_i, "ack must follow stb");
		end
		if (wb_stb_i && !wb_we_i) begin
			exp = (wb_adr_i == 0) ? reg_phase : (wb_adr_i == 1) ? reg_bypass : 0;
			compare("s_wb_dat_o", exp, wb_rdat_i, $sformatf("read adr 0x%0h", wb_adr_i));
		end
	endtask

	task automatic check_ready();
		if (flushing) begin
			if (!img_ready_i) begin
				flush_cycles++;
			end else begin
				if (flush_cycles != width + 1) begin
					fail_msg($sformatf("ready was low for %0d cycles after frame end, expected %0d",
						flush_cycles, width + 1));
				end
				flushing = 1'b0;
			end
		end else if (!img_ready_i) begin
			fail_msg("ready went low outside the end-of-frame flush");
		end
	endtask

	task automatic check_output();
		int    x;
		int    y;
		int    c;
		int    up;
		int    dn;
		int    lf;
		int    rt;
		int    dg;
		int    er;
		int    eg;
		int    eb;
		logic  cx;
		logic  cy;
		string where;
		if (!in_frame || width == 0) begin
			fail_msg("output beat seen with no frame in progress");
			return;
		end
		x  = out_cnt % width;
		y  = out_cnt / width;
		c  = pix_at(x, y);
		up = pix_at(x, y - 1);
		dn = pix_at(x, y + 1);
		lf = pix_at(x - 1, y);
		rt = pix_at(x + 1, y);
		dg = pix_at(x - 1, y - 1) + pix_at(x + 1, y - 1) + pix_at(x - 1, y + 1)
			+ pix_at(x + 1, y + 1);
		cx = x[0] ^ frm_phase[0];
		cy = y[0] ^ frm_phase[1];
		if (frm_bypass) begin
			er = c;
			eg = c;
			eb = c;
		end else if (!cx && !cy) begin
			er = c;
			eg = (up + dn + lf + rt) / 4;
			eb = dg / 4;
		end else if (cx && cy) begin
			er = dg / 4;
			eg = (up + dn + lf + rt) / 4;
			eb = c;
		end else if (!cy) begin
			// green on a red row
			er = (lf + rt) / 2;
			eg = c;
			eb = (up + dn) / 2;
		end else begin
			er = (up + dn) / 2;
			eg = c;
			eb = (lf + rt) / 2;
		end
		where = $sformatf("frame %0d x %0d y %0d", frames_o, x, y);
		compare("m_img_beat_o.r", er, out_beat_i.r, where);
		compare("m_img_beat_o.g", eg, out_beat_i.g, where);
		compare("m_img_beat_o.b", eb, out_beat_i.b, where);
		compare("m_img_beat_o.raw", c, out_beat_i.raw, where);
		compare("m_img_beat_o.line_first", y == 0, out_beat_i.line_first, where);
		compare("m_img_beat_o.line_last", ended && y == height - 1, out_beat_i.line_last, where);
		compare("m_img_beat_o.pixel_first", x == 0, out_beat_i.pixel_first, where);
		compare("m_img_beat_o.pixel_last", x == width - 1, out_beat_i.pixel_last, where);
		out_cnt++;
		if (ended && out_cnt == width * height) begin
			frames_o++;
			in_frame = 1'b0;
		end
	endtask

	task automatic take_beat();
		if (!in_frame) begin
			// anything but a frame start is dropped while idle
			if (!(img_beat_i.line_first && img_beat_i.pixel_first)) begin
				return;
			end
			in_frame   = 1'b1;
			ended      = 1'b0;
			width      = 0;
			height     = 0;
			out_cnt    = 0;
			frm_phase  = reg_phase;
			frm_bypass = reg_bypass;
			pix_q.delete();
		end else if (ended) begin
			fail_msg($sformatf("input beat accepted before frame end, %0d of %0d outputs seen",
				out_cnt, width * height));
			return;
		end
		pix_q.push_back(img_beat_i.raw);
		if (width == 0 && img_beat_i.pixel_last) begin
			width = pix_q.size();
		end
		if (img_beat_i.line_last && img_beat_i.pixel_last) begin
			ended        = 1'b1;
			height       = pix_q.size() / width;
			flushing     = 1'b1;
			flush_cycles = 0;
		end
	endtask

	// a write lands at this edge, after a frame start in the same cycle has latched
	task automatic store_write();
		if (wb_stb_i && wb_we_i) begin
			if (wb_adr_i == 0) begin
				reg_phase = wb_wdat_i[1:0];
			end else if (wb_adr_i == 1) begin
				reg_bypass = wb_wdat_i[0];
			end
		end
	endtask

	always @(posedge clk) begin
		if (s_wb_rst_i) begin
			reg_phase  = 2'd3;
			reg_bypass = 1'b0;
			in_frame   = 1'b0;
			ended      = 1'b0;
			flushing   = 1'b0;
			width      = 0;
		end else begin
			check_bus();
			check_ready();
			// the last output of a frame can share an edge with the next start beat
			if (out_valid_i) begin
				check_output();
			end
			if (img_valid_i && img_ready_i) begin
				take_beat();
			end
			store_write();
		end
	end

endmodule

// ==== dv/tb_demosaic.sv ====
// testbench top with lfsr, wishbone tasks, frame stimulus, timeout and summary
`timescale 1ns/1ps

module tb_demosaic
	import demosaic_pkg::*;
();

	logic        clk;
	logic        s_wb_rst_i;
	wb_adr_t     wb_adr;
	wb_dat_t     wb_wdat;
	wb_dat_t     wb_rdat;
	logic        wb_we;
	logic        wb_stb;
	logic        wb_ack;
	logic        img_valid;
	raw_beat_t   img_beat;
	logic        img_ready;
	logic        out_valid;
	rgb_beat_t   out_beat;
	int          err_cnt;
	int          frames_done;
	logic [31:0] lfsr_state;
	int          cycle_cnt;
	int          cycle_limit;
	int          frames_sent;
	int          tests_passed;
	int          tests_failed;

	tb_clk_gen clk_gen_i (
		.clk_o (clk),
		.rst_o (s_wb_rst_i)
	);

	demosaic_top dut_i (
		.clk           (clk),
		.s_wb_rst_i    (s_wb_rst_i),
		.s_wb_adr_i    (wb_adr),
		.s_wb_dat_i    (wb_wdat),
		.s_wb_dat_o    (wb_rdat),
		.s_wb_we_i     (wb_we),
		.s_wb_stb_i    (wb_stb),
		.s_wb_ack_o    (wb_ack),
		.s_img_valid_i (img_valid),
		.s_img_beat_i  (img_beat),
		.s_img_ready_o (img_ready),
		.m_img_valid_o (out_valid),
		.m_img_beat_o  (out_beat)
	);

	tb_demosaic_chk chk_i (
		.clk         (clk),
		.s_wb_rst_i  (s_wb_rst_i),
		.wb_adr_i    (wb_adr),
		.wb_wdat_i   (wb_wdat),
		.wb_rdat_i   (wb_rdat),
		.wb_we_i     (wb_we),
		.wb_stb_i    (wb_stb),
		.wb_ack_i    (wb_ack),
		.img_valid_i (img_valid),
		.img_beat_i  (img_beat),
		.img_ready_i (img_ready),
		.out_valid_i (out_valid),
		.out_beat_i  (out_beat),
		.err_cnt_o   (err_cnt),
		.frames_o    (frames_done)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int next_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
		cycle_limit += 4;
		wb_adr  = adr;
		wb_wdat = dat;
		wb_we   = 1'b1;
		wb_stb  = 1'b1;
		@(posedge clk);
		#1;
		wb_we  = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic read_reg(input wb_adr_t adr);
		cycle_limit += 4;
		wb_adr = adr;
		wb_we  = 1'b0;
		wb_stb = 1'b1;
		@(posedge clk);
		#1;
		wb_stb = 1'b0;
	endtask

	// ready only changes on an edge, so it is stable at the drive point
	task automatic send_beat(input raw_beat_t beat);
		img_beat  = beat;
		img_valid = 1'b1;
		while (!img_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		img_valid = 1'b0;
	endtask

	task automatic send_frame(input int w, input int h, input bit mid_write);
		raw_beat_t beat;
		int        gap;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				gap = (next_bits(2) == 0) ? 1 + next_bits(2) : 0;
				cycle_limit += 4 * (gap + 1);
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				if (mid_write && y * w + x == (w * h) / 2) begin
					write_reg(REG_ADR_PHASE, 32'd2);
					write_reg(REG_ADR_BYPASS, 32'd1);
				end
				beat.raw         = pix_t'(next_bits(PIX_W));
				beat.line_first  = (y == 0);
				beat.line_last   = (y == h - 1);
				beat.pixel_first = (x == 0);
				beat.pixel_last  = (x == w - 1);
				send_beat(beat);
			end
		end
		// flush slots plus the output register
		cycle_limit += 4 * (w + 2);
		frames_sent++;
	endtask

	task automatic random_frame(input bit mid_write);
		int w;
		int h;
		w = 2 + next_bits(4) % 15;
		h = 2 + next_bits(3) % 7;
		send_frame(w, h, mid_write);
	endtask

	task automatic wait_frames();
		while (frames_done < frames_sent) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - err_before);
		end
	endtask

	task automatic test_regs();
		int e;
		e = err_cnt;
		read_reg(REG_ADR_PHASE);
		read_reg(REG_ADR_BYPASS);
		write_reg(REG_ADR_PHASE, 32'hffff_fff1);
		read_reg(REG_ADR_PHASE);
		write_reg(REG_ADR_BYPASS, 32'h0000_0003);
		read_reg(REG_ADR_BYPASS);
		write_reg(REG_ADR_BYPASS, 32'd0);
		read_reg(REG_ADR_BYPASS);
		for (int a = 2; a < 16; a++) begin
			read_reg(wb_adr_t'(a));
		end
		finish_test("register access", e);
	endtask

	task automatic test_phases();
		int e;
		e = err_cnt;
		for (int p = 0; p < 4; p++) begin
			write_reg(REG_ADR_PHASE, wb_dat_t'(p));
			random_frame(1'b0);
			random_frame(1'b0);
		end
		wait_frames();
		finish_test("interpolation over all phases", e);
	endtask

	task automatic test_bypass();
		int e;
		e = err_cnt;
		write_reg(REG_ADR_BYPASS, 32'd1);
		random_frame(1'b0);
		random_frame(1'b0);
		wait_frames();
		write_reg(REG_ADR_BYPASS, 32'd0);
		finish_test("bypass", e);
	endtask

	task automatic test_mid_write();
		int e;
		e = err_cnt;
		write_reg(REG_ADR_PHASE, 32'd1);
		random_frame(1'b1);
		random_frame(1'b0);
		wait_frames();
		write_reg(REG_ADR_BYPASS, 32'd0);
		finish_test("register write during a frame", e);
	endtask

	task automatic test_flow();
		int        e;
		raw_beat_t stray;
		e = err_cnt;
		// a beat without frame-start flags is dropped while idle
		stray = '0;
		stray.raw = pix_t'(next_bits(PIX_W));
		cycle_limit += 4;
		send_beat(stray);
		// back to back, so the next start beat waits out the flush
		send_frame(16, 8, 1'b0);
		send_frame(2, 2, 1'b0);
		random_frame(1'b0);
		wait_frames();
		finish_test("flow and markers", e);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		wb_adr       = '0;
		wb_wdat      = '0;
		wb_we        = 1'b0;
		wb_stb       = 1'b0;
		img_valid    = 1'b0;
		img_beat     = '0;
		lfsr_state   = 32'h25c96fb3;
		cycle_cnt    = 0;
		cycle_limit  = 32;
		frames_sent  = 0;
		tests_passed = 0;
		tests_failed = 0;
		wait (!s_wb_rst_i);
		@(posedge clk);
		#1;
		test_regs();
		test_phases();
		test_bypass();
		test_mid_write();
		test_flow();
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== demosaic.f ====
src/demosaic_pkg.sv
src/demosaic_regs.sv
src/demosaic_scan_ctrl.sv
src/demosaic_pos_cnt.sv
src/demosaic_line_buf.sv
src/demosaic_interp.sv
src/demosaic_top.sv
dv/tb_clk_gen.sv
dv/tb_demosaic_chk.sv
dv/tb_demosaic.sv
